/* source/spi_regs_cfg.svh */
// SPI register bank configuration
// frame layout, register file size, special register indices
// and the 4094 serializer clock divider
`ifndef SPI_REGS_CFG_SVH
`define SPI_REGS_CFG_SVH

// one SPI frame is a header byte followed by 24 data bits
`define SPI_REGS_FRAME_BITS 32

// register address and register width
`define SPI_REGS_ADDR_BITS 6
`define SPI_REGS_DATA_BITS 24

// number of registers, 2**addr bits
`define SPI_REGS_NUM 64

// registers with a direct output port
`define SPI_REGS_LED 7
`define SPI_REGS_SPI_MUX 8
`define SPI_REGS_4094 9

// led register comes up with every other bit lit
`define SPI_REGS_LED_RESET 24'hAAAAAA

// cs cycles per half period of the 4094 shift clock
`define SPI_REGS_4094_DIV 2

`endif

/* source/spi_regs_pkg.sv */
// SPI register bank types
// address, register value and the 32 bit frame layout
// shared by the frame engine, register file and top level
`default_nettype none

`include "spi_regs_cfg.svh"

package spi_regs_pkg;

  // register address, carried in the low bits of the header byte
  typedef logic [`SPI_REGS_ADDR_BITS-1:0] reg_addr_t;

  // one register value
  typedef logic [`SPI_REGS_DATA_BITS-1:0] reg_data_t;

  // frame as seen once all 32 bits are shifted in, msb first
  // write_n low selects a write, spare is ignored
  typedef struct packed {
    logic      write_n;
    logic      spare;
    reg_addr_t addr;
    reg_data_t data;
  } spi_frame_t;

endpackage

`default_nettype wire

/* source/reg_bus_if.sv */
// register bus between the SPI frame engine and the register file
// combinational read port plus a single cycle write strobe
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;

  // read port, data follows the address in the same cycle
  spi_regs_pkg::reg_addr_t rd_addr;
  spi_regs_pkg::reg_data_t rd_data;

  // write port, written at the cs edge where wr_en is high
  logic                    wr_en;
  spi_regs_pkg::reg_addr_t wr_addr;
  spi_regs_pkg::reg_data_t wr_data;

  // frame engine side
  modport engine (
    output rd_addr,
    input  rd_data,
    output wr_en,
    output wr_addr,
    output wr_data
  );

  // register file side
  modport regs (
    input  rd_addr,
    output rd_data,
    input  wr_en,
    input  wr_addr,
    input  wr_data
  );

endinterface

`default_nettype wire

/* source/spi_frame_engine.sv */
// SPI mode 0 frame engine
// oversamples sclk, ss_n and mosi in the cs domain, shifts in a
// 32 bit frame, returns the addressed register on miso during the
// last 24 bits and issues a register write when a full write frame
// ends
`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_cfg.svh"

module spi_frame_engine (
  input  wire       cs,
  input  wire       rst_n,
  input  wire       sclk,
  input  wire       ss_n,
  input  wire       mosi,
  output logic      miso,
  reg_bus_if.engine bus
);

  localparam int FRAME_BITS = `SPI_REGS_FRAME_BITS;
  localparam int DATA_BITS  = `SPI_REGS_DATA_BITS;
  localparam int ADDR_BITS  = `SPI_REGS_ADDR_BITS;
  // header byte ahead of the data field
  localparam int HDR_BITS   = FRAME_BITS - DATA_BITS;
  localparam int CNT_W      = $clog2(FRAME_BITS) + 1;

  localparam logic [CNT_W-1:0] CNT_HDR   = CNT_W'(HDR_BITS);
  localparam logic [CNT_W-1:0] CNT_FRAME = CNT_W'(FRAME_BITS);

  // two synchronizer flops, the third sclk and ss_n flop is the edge history
  logic [2:0]            sclk_sync;
  logic [2:0]            ss_sync;
  logic [1:0]            mosi_sync;

  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  ss_rise;
  logic                  ss_idle;

  logic [CNT_W-1:0]      bit_cnt;
  logic [FRAME_BITS-1:0] in_shift;
  logic [DATA_BITS-1:0]  out_shift;

  spi_regs_pkg::spi_frame_t frame;

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_sync <= 3'b000;
      // select idles high
      ss_sync   <= 3'b111;
      mosi_sync <= 2'b00;
    end
    else
    begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      ss_sync   <= {ss_sync[1:0], ss_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  // edges seen on the synchronized copies, acted on one cycle later
  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign ss_rise   = ss_sync[1] & ~ss_sync[2];
  assign ss_idle   = ss_sync[1];

  // full frame view of the input shifter
  assign frame = in_shift;

  // after the header byte the address sits in the low shifter bits
  assign bus.rd_addr = in_shift[ADDR_BITS-1:0];

  assign miso = out_shift[DATA_BITS-1];

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt   <= '0;
      in_shift  <= '0;
      out_shift <= '0;
    end
    else if (ss_idle)
    begin
      // no frame in progress, also keeps miso low
      bit_cnt   <= '0;
      in_shift  <= '0;
      out_shift <= '0;
    end
    else
    begin
      // mosi sampled on rising sclk
      if (sclk_rise)
      begin
        in_shift <= {in_shift[FRAME_BITS-2:0], mosi_sync[1]};
        // saturate so long frames never wrap back to 32
        if (bit_cnt != '1)
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      // miso moves on falling sclk
      if (sclk_fall)
      begin
        if (bit_cnt == CNT_HDR)
        begin
          // first falling edge after the header, data bit 23 goes out
          out_shift <= bus.rd_data;
        end
        else
        begin
          out_shift <= {out_shift[DATA_BITS-2:0], 1'b0};
        end
      end
    end
  end

  // write strobe on the end of an exact length write frame
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bus.wr_en <= 1'b0;
    end
    else
    begin
      bus.wr_en <= ss_rise && (bit_cnt == CNT_FRAME) && !frame.write_n;
    end
  end

  // write payload, only meaningful with wr_en
  always_ff @(posedge cs)
  begin
    if (ss_rise)
    begin
      bus.wr_addr <= frame.addr;
      bus.wr_data <= frame.data;
    end
  end

endmodule

`default_nettype wire

/* source/reg_file.sv */
// register file of the SPI register bank
// 64 registers of 24 bits, any of them writable, with the led,
// spi mux and 4094 registers brought out as ports and a load
// strobe to the 4094 serializer after each write to register 9
`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_cfg.svh"

module reg_file (
  input  wire                     cs,
  input  wire                     rst_n,
  reg_bus_if.regs                 bus,
  output spi_regs_pkg::reg_data_t reg_led,
  output spi_regs_pkg::reg_data_t reg_spi_mux,
  output spi_regs_pkg::reg_data_t reg_4094,
  output logic                    load_4094
);

  spi_regs_pkg::reg_data_t regs [`SPI_REGS_NUM];

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `SPI_REGS_NUM; i++)
      begin
        // led starts with the alternating pattern, everything else clear
        regs[i] <= (i == `SPI_REGS_LED) ? `SPI_REGS_LED_RESET : '0;
      end
    end
    else if (bus.wr_en)
    begin
      regs[bus.wr_addr] <= bus.wr_data;
    end
  end

  // read is a plain mux on the address
  assign bus.rd_data = regs[bus.rd_addr];

  // direct register outputs
  assign reg_led     = regs[`SPI_REGS_LED];
  assign reg_spi_mux = regs[`SPI_REGS_SPI_MUX];
  assign reg_4094    = regs[`SPI_REGS_4094];

  // pulse lines up with the new reg_4094 value
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      load_4094 <= 1'b0;
    end
    else
    begin
      load_4094 <= bus.wr_en &&
                   (bus.wr_addr == spi_regs_pkg::reg_addr_t'(`SPI_REGS_4094));
    end
  end

endmodule

`default_nettype wire

/* source/shift_4094_driver.sv */
// 4094 shift register chain driver
// clocks a 24 bit value into the chain msb first and then strobes
// it to the chain outputs; a load during a run restarts the chain
// with the newest value once the run ends
`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_cfg.svh"

module shift_4094_driver (
  input  wire                     cs,
  input  wire                     rst_n,
  input  spi_regs_pkg::reg_data_t value,
  input  wire                     load,
  output logic                    ser_clk,
  output logic                    ser_data,
  output logic                    ser_strobe
);

  localparam int DATA_BITS = `SPI_REGS_DATA_BITS;
  localparam int DIV       = `SPI_REGS_4094_DIV;
  localparam int DIV_W     = (DIV > 1) ? $clog2(DIV) : 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_SHIFT,
    S_STROBE
  } state_t;

  state_t               state;
  logic [DIV_W-1:0]     div_cnt;
  logic [4:0]           bit_cnt;
  logic [DATA_BITS-1:0] shift_reg;
  logic                 pending;
  logic                 half_done;

  // last cycle of a half period
  assign half_done = (div_cnt == DIV_W'(DIV - 1));

  // data line only carries bits during a run
  assign ser_data   = (state == S_SHIFT) ? shift_reg[DATA_BITS-1] : 1'b0;
  assign ser_strobe = (state == S_STROBE);

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      shift_reg <= '0;
      pending   <= 1'b0;
      ser_clk   <= 1'b0;
    end
    else
    begin
      // remember a load that lands mid run
      if (load && state != S_IDLE)
      begin
        pending <= 1'b1;
      end
      div_cnt <= half_done ? '0 : div_cnt + 1'b1;
      case (state)
        S_IDLE:
        begin
          div_cnt <= '0;
          if (load || pending)
          begin
            // value always holds the newest register 9 contents
            shift_reg <= value;
            bit_cnt   <= '0;
            pending   <= 1'b0;
            state     <= S_SHIFT;
          end
        end
        S_SHIFT:
        begin
          if (half_done)
          begin
            ser_clk <= ~ser_clk;
            // end of the high half closes one bit
            if (ser_clk)
            begin
              if (bit_cnt == 5'(DATA_BITS - 1))
              begin
                state <= S_STROBE;
              end
              else
              begin
                bit_cnt   <= bit_cnt + 1'b1;
                shift_reg <= {shift_reg[DATA_BITS-2:0], 1'b0};
              end
            end
          end
        end
        S_STROBE:
        begin
          // strobe lasts one half period with ser_clk low
          if (half_done)
          begin
            state <= S_IDLE;
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/spi_reg_bank.sv */
// SPI register bank top level
// SPI slave frame engine, 64 entry register file and the 4094
// serializer, all in the cs clock domain
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bank (
  input  wire                     cs,
  input  wire                     rst_n,
  input  wire                     sclk,
  input  wire                     ss_n,
  input  wire                     mosi,
  output logic                    miso,
  output spi_regs_pkg::reg_data_t reg_led,
  output spi_regs_pkg::reg_data_t reg_spi_mux,
  output logic                    ser_clk,
  output logic                    ser_data,
  output logic                    ser_strobe
);

  // register 9 value and its update strobe
  spi_regs_pkg::reg_data_t reg_4094;
  logic                    load_4094;

  reg_bus_if bus ();

  spi_frame_engine i_engine (
    .cs    (cs),
    .rst_n (rst_n),
    .sclk  (sclk),
    .ss_n  (ss_n),
    .mosi  (mosi),
    .miso  (miso),
    .bus   (bus.engine)
  );

  reg_file i_regs (
    .cs          (cs),
    .rst_n       (rst_n),
    .bus         (bus.regs),
    .reg_led     (reg_led),
    .reg_spi_mux (reg_spi_mux),
    .reg_4094    (reg_4094),
    .load_4094   (load_4094)
  );

  shift_4094_driver i_ser (
    .cs         (cs),
    .rst_n      (rst_n),
    .value      (reg_4094),
    .load       (load_4094),
    .ser_clk    (ser_clk),
    .ser_data   (ser_data),
    .ser_strobe (ser_strobe)
  );

endmodule

`default_nettype wire

/* verification/spi_reg_bank_assertions.sv */
// protocol checks for the SPI register bank
// bound once into the frame engine and once into the 4094 driver;
// each binding ties off the inputs it has no use for
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bank_assertions (
  input wire cs,
  input wire rst_n,
  input wire wr_en,
  input wire ss_n,
  input wire miso,
  input wire ser_clk,
  input wire ser_strobe,
  input wire ser_idle
);

  // register write strobe is a single cycle pulse
  a_wr_en_pulse: assert property (@(posedge cs) disable iff (!rst_n)
    wr_en |=> !wr_en)
    else $error("wr_en stayed high for more than one cycle");

  // select pin high long enough to pass the synchronizer and
  // clear the output shifter
  a_miso_idle: assert property (@(posedge cs) disable iff (!rst_n)
    ss_n [*4] |-> !miso)
    else $error("miso driven while ss_n is high");

  // latch strobe only in the low phase of the shift clock
  a_strobe_clk_low: assert property (@(posedge cs) disable iff (!rst_n)
    ser_strobe |-> !ser_clk)
    else $error("ser_strobe high while ser_clk is high");

  // chain clock parked low between runs
  a_idle_clk_low: assert property (@(posedge cs) disable iff (!rst_n)
    ser_idle |-> !ser_clk)
    else $error("ser_clk high while the 4094 driver is idle");

endmodule

`default_nettype wire

/* verification/tb_spi_reg_bank.sv */
// testbench for the SPI register bank
// drives random mode 0 SPI frames, keeps a register model and
// watches the 4094 chain output for each register 9 update
`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_cfg.svh"

module tb_spi_reg_bank;

  // sclk half period in cs cycles, cycle limit for every wait
  localparam int HALF_SCLK = 6;
  localparam int TIMEOUT   = 2000;

  logic cs;
  logic rst_n;
  logic sclk;
  logic ss_n;
  logic mosi;
  logic miso;
  logic ser_clk;
  logic ser_data;
  logic ser_strobe;
  spi_regs_pkg::reg_data_t reg_led;
  spi_regs_pkg::reg_data_t reg_spi_mux;

  // register model, updated after each complete write frame
  spi_regs_pkg::reg_data_t model [`SPI_REGS_NUM];

  int value_errors;
  int timeout_errors;
  int writes_4094;
  int strobes_4094;
  spi_regs_pkg::reg_data_t last_4094;

  spi_reg_bank i_dut (
    .cs          (cs),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .ss_n        (ss_n),
    .mosi        (mosi),
    .miso        (miso),
    .reg_led     (reg_led),
    .reg_spi_mux (reg_spi_mux),
    .ser_clk     (ser_clk),
    .ser_data    (ser_data),
    .ser_strobe  (ser_strobe)
  );

  bind spi_frame_engine spi_reg_bank_assertions i_engine_chk (
    .cs         (cs),
    .rst_n      (rst_n),
    .wr_en      (bus.wr_en),
    .ss_n       (ss_n),
    .miso       (miso),
    .ser_clk    (1'b0),
    .ser_strobe (1'b0),
    .ser_idle   (1'b1)
  );

  bind shift_4094_driver spi_reg_bank_assertions i_ser_chk (
    .cs         (cs),
    .rst_n      (rst_n),
    .wr_en      (1'b0),
    .ss_n       (1'b0),
    .miso       (1'b0),
    .ser_clk    (ser_clk),
    .ser_strobe (ser_strobe),
    .ser_idle   (state == S_IDLE)
  );

  initial cs = 1'b0;
  always #2 cs = ~cs;

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge cs);
  endtask

  task automatic check_value(input string name, input spi_regs_pkg::reg_data_t expected,
                             input spi_regs_pkg::reg_data_t actual);
    assert (actual === expected)
    else
    begin
      value_errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // frame layout: write_n, spare, 6 bit address, 24 bit data
  function automatic logic [31:0] make_frame(input logic write_n,
                                             input spi_regs_pkg::reg_addr_t addr,
                                             input spi_regs_pkg::reg_data_t data);
    spi_regs_pkg::spi_frame_t f;
    f.write_n = write_n;
    f.spare   = 1'b0;
    f.addr    = addr;
    f.data    = data;
    return f;
  endfunction

  // shifts nbits of word out msb first, miso captured just before each
  // rising sclk; frame bit i carries data bit 31-i on the way back
  task automatic spi_transfer(input logic [31:0] word, input int nbits,
                              output spi_regs_pkg::reg_data_t rd);
    rd = '0;
    @(posedge cs);
    ss_n <= 1'b0;
    sclk <= 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      mosi <= word[31-i];
      wait_cycles(HALF_SCLK);
      if (i >= 8)
      begin
        rd[31-i] = miso;
      end
      sclk <= 1'b1;
      wait_cycles(HALF_SCLK);
      sclk <= 1'b0;
    end
    wait_cycles(HALF_SCLK);
    ss_n <= 1'b1;
    mosi <= 1'b0;
    wait_cycles(HALF_SCLK);
  endtask

  // every frame reads back the value held before its own write
  task automatic write_reg(input string name, input spi_regs_pkg::reg_addr_t addr,
                           input spi_regs_pkg::reg_data_t data);
    spi_regs_pkg::reg_data_t rd;
    spi_transfer(make_frame(1'b0, addr, data), `SPI_REGS_FRAME_BITS, rd);
    check_value({name, " old value"}, model[addr], rd);
    model[addr] = data;
    if (addr == `SPI_REGS_4094)
    begin
      writes_4094++;
    end
  endtask

  task automatic read_reg(input string name, input spi_regs_pkg::reg_addr_t addr);
    spi_regs_pkg::reg_data_t rd;
    spi_transfer(make_frame(1'b1, addr, spi_regs_pkg::reg_data_t'($urandom)),
                 `SPI_REGS_FRAME_BITS, rd);
    check_value(name, model[addr], rd);
  endtask

  // led or spi mux output, selected by register index
  task automatic wait_output(input string name, input int idx);
    spi_regs_pkg::reg_data_t actual;
    int n;
    n = 0;
    actual = (idx == `SPI_REGS_LED) ? reg_led : reg_spi_mux;
    while (actual !== model[idx] && n < TIMEOUT)
    begin
      @(posedge cs);
      n++;
      actual = (idx == `SPI_REGS_LED) ? reg_led : reg_spi_mux;
    end
    assert (n < TIMEOUT)
    else
    begin
      timeout_errors++;
      $display("timeout while waiting for %s to follow its register", name);
    end
    check_value(name, model[idx], actual);
  endtask

  task automatic wait_4094_done(input string name);
    int n;
    n = 0;
    while (strobes_4094 != writes_4094 && n < TIMEOUT)
    begin
      @(posedge cs);
      n++;
    end
    assert (n < TIMEOUT)
    else
    begin
      timeout_errors++;
      $display("timeout in %s, %0d chain updates seen for %0d writes", name,
               strobes_4094, writes_4094);
    end
  endtask

  // rebuilds each chain word from ser_data at rising ser_clk
  task automatic watch_4094();
    spi_regs_pkg::reg_data_t word;
    int nbits;
    logic clk_q;
    logic strobe_q;
    word = '0;
    nbits = 0;
    clk_q = 1'b0;
    strobe_q = 1'b0;
    forever
    begin
      @(posedge cs);
      if (ser_clk && !clk_q)
      begin
        word = {word[`SPI_REGS_DATA_BITS-2:0], ser_data};
        nbits++;
      end
      if (ser_strobe && !strobe_q)
      begin
        strobes_4094++;
        last_4094 = word;
        // chain always ends with the newest register 9 value
        check_value("ser_4094 word", model[`SPI_REGS_4094], word);
        assert (nbits == `SPI_REGS_DATA_BITS)
        else
        begin
          value_errors++;
          $display("FAILED ser_4094 bit count: expected %0d, actual %0d",
                   `SPI_REGS_DATA_BITS, nbits);
        end
        nbits = 0;
      end
      clk_q = ser_clk;
      strobe_q = ser_strobe;
    end
  endtask

  initial watch_4094();

  initial
  begin
    spi_regs_pkg::reg_addr_t addr;
    spi_regs_pkg::reg_data_t data;
    spi_regs_pkg::reg_data_t rd;
    int nbits;
    void'($urandom(11));
    value_errors = 0;
    timeout_errors = 0;
    writes_4094 = 0;
    strobes_4094 = 0;
    last_4094 = '0;
    for (int i = 0; i < `SPI_REGS_NUM; i++)
    begin
      model[i] = (i == `SPI_REGS_LED) ? `SPI_REGS_LED_RESET : '0;
    end
    rst_n = 1'b0;
    sclk = 1'b0;
    ss_n = 1'b1;
    mosi = 1'b0;
    wait_cycles(4);
    rst_n <= 1'b1;
    wait_cycles(4);

    // reset values
    read_reg("reset_led", `SPI_REGS_LED);
    read_reg("reset_spi_mux", `SPI_REGS_SPI_MUX);
    read_reg("reset_4094", `SPI_REGS_4094);
    check_value("reset_led_port", `SPI_REGS_LED_RESET, reg_led);

    // random write then read back
    for (int k = 0; k < 20; k++)
    begin
      addr = spi_regs_pkg::reg_addr_t'($urandom_range(`SPI_REGS_NUM - 1));
      data = spi_regs_pkg::reg_data_t'($urandom);
      write_reg("random_write", addr, data);
      read_reg("random_read", addr);
    end

    // direct output ports
    write_reg("led_write", `SPI_REGS_LED, spi_regs_pkg::reg_data_t'($urandom));
    wait_output("led_port", `SPI_REGS_LED);
    write_reg("mux_write", `SPI_REGS_SPI_MUX, spi_regs_pkg::reg_data_t'($urandom));
    wait_output("spi_mux_port", `SPI_REGS_SPI_MUX);

    // short frames must not write
    for (int k = 0; k < 8; k++)
    begin
      addr = spi_regs_pkg::reg_addr_t'($urandom_range(`SPI_REGS_NUM - 1));
      data = spi_regs_pkg::reg_data_t'($urandom);
      nbits = 1 + $urandom_range(30);
      spi_transfer(make_frame(1'b0, addr, data), nbits, rd);
      read_reg("short_frame", addr);
    end

    // a cut frame holds only part of its header, so a stray write
    // could land on any address
    for (int k = 0; k < `SPI_REGS_NUM; k++)
    begin
      read_reg("short_frame_sweep", spi_regs_pkg::reg_addr_t'(k));
    end

    // register 9 to the 4094 chain, then two writes in a row
    wait_4094_done("chain_drain");
    write_reg("chain_write", `SPI_REGS_4094, spi_regs_pkg::reg_data_t'($urandom));
    wait_4094_done("chain_single");
    write_reg("chain_first", `SPI_REGS_4094, spi_regs_pkg::reg_data_t'($urandom));
    write_reg("chain_second", `SPI_REGS_4094, spi_regs_pkg::reg_data_t'($urandom));
    wait_4094_done("chain_back_to_back");
    check_value("chain_latest", model[`SPI_REGS_4094], last_4094);
    wait_cycles(10);

    $display("error counts: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+source
source/spi_regs_pkg.sv
source/reg_bus_if.sv
source/spi_frame_engine.sv
source/reg_file.sv
source/shift_4094_driver.sv
source/spi_reg_bank.sv
verification/spi_reg_bank_assertions.sv
verification/tb_spi_reg_bank.sv
